/* all.f */
hdl/usbPacketPkg.sv
hdl/rxCtrlPkg.sv
hdl/nrziUnstuff.sv
hdl/rxDeserializer.sv
hdl/usbCrcCheck.sv
hdl/rxPacketFsm.sv
hdl/rxOutputStage.sv
hdl/usbRx.sv
verif/usbRxAssertions.sv
verif/usbRxTb.sv

/* hdl/nrziUnstuff.sv */
`timescale 1ns/1ps
`default_nettype none

module nrziUnstuff (
    input  wire logic clk12_i,
    input  wire logic rstN_i,
    input  wire logic restart_i,
    input  wire logic dataP_i,
    output logic      decodedBit_o,
    output logic      bitValid_o,
    output logic      stuffError_o
);

    localparam int CNT_W = $clog2(usbPacketPkg::STUFF_RUN + 1);
    localparam logic [CNT_W-1:0] RUN_FULL = CNT_W'(usbPacketPkg::STUFF_RUN);

    logic             prevSample;
    logic [CNT_W-1:0] onesCnt;
    logic             nrziBit;
    logic             stuffSlot;

    // No level change on the line means a one
    assign nrziBit = (dataP_i == prevSample);

    // Bit position right after a full run of ones
    assign stuffSlot = (onesCnt == RUN_FULL);

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            prevSample   <= 1'b1;
            onesCnt      <= '0;
            decodedBit_o <= 1'b1;
            bitValid_o   <= 1'b0;
            stuffError_o <= 1'b0;
        end else begin
            // Back to idle J on restart
            prevSample   <= restart_i ? 1'b1 : dataP_i;
            decodedBit_o <= nrziBit;
            bitValid_o   <= !stuffSlot;
            // A one where a stuffed zero belongs
            stuffError_o <= stuffSlot && nrziBit;
            if (restart_i || stuffSlot || !nrziBit) begin
                onesCnt <= '0;
            end else begin
                onesCnt <= onesCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rxCtrlPkg.sv */
`default_nettype none

package rxCtrlPkg;

    // Packet level receive states
    typedef enum logic [1:0] {
        WAIT_SYNC,
        GET_PID,
        WAIT_EOP,
        RST_PHASE
    } rxState_e;

    // Output side states
    typedef enum logic [0:0] {
        KEEP_FILLED,
        WAIT_EMPTY
    } ifaceState_e;

    // Cycles allowed for the buffer to drain after EOP
    localparam int FLUSH_TIMEOUT_DEFAULT = 3;

endpackage

`default_nettype wire

/* hdl/rxDeserializer.sv */
`timescale 1ns/1ps
`default_nettype none

module rxDeserializer (
    input  wire logic       clk12_i,
    input  wire logic       rstN_i,
    input  wire logic       restart_i,
    input  wire logic       clear_i,
    input  wire logic       bit_i,
    input  wire logic       bitValid_i,
    output logic      [7:0] byteData_o,
    output logic            byteFull_o,
    output logic            syncDetect_o
);

    logic [7:0] shiftReg;
    logic [2:0] bitCnt;

    assign byteData_o = shiftReg;

    // Newest four bits sit at the top of the register
    assign syncDetect_o = (shiftReg[7:4] == usbPacketPkg::SYNC_TAIL);

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            shiftReg   <= '1;
            bitCnt     <= '0;
            byteFull_o <= 1'b0;
        end else begin
            // Strobe once the eighth bit has been shifted in
            byteFull_o <= bitValid_i && (bitCnt == 3'd7) && !restart_i;

            // LSB first on the wire, so shift toward bit 0
            if (clear_i) begin
                shiftReg <= '1;
            end else if (bitValid_i) begin
                shiftReg <= {bit_i, shiftReg[7:1]};
            end

            // First PID bit may already arrive in the restart cycle
            if (restart_i) begin
                bitCnt <= bitValid_i ? 3'd1 : 3'd0;
            end else if (bitValid_i) begin
                bitCnt <= bitCnt + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rxOutputStage.sv */
`timescale 1ns/1ps
`default_nettype none

module rxOutputStage #(
    parameter int FLUSH_TIMEOUT = rxCtrlPkg::FLUSH_TIMEOUT_DEFAULT
) (
    input  wire logic       clk12_i,
    input  wire logic       rstN_i,
    input  wire logic       gotByte_i,
    input  wire logic [7:0] byteData_i,
    input  wire logic       gotEop_i,
    input  wire logic       dropPacket_i,
    input  wire logic       needCrc16_i,
    input  wire logic       rxAccept_i,
    output logic            rxDataValid_o,
    output logic      [7:0] rxData_o,
    output logic            rxDone_o,
    output logic            keepPacket_o
);

    localparam int TIMER_W = $clog2(FLUSH_TIMEOUT + 1);

    logic [7:0]             bufMem [2];
    logic                   rdPtr;
    logic                   wrPtr;
    logic [1:0]             fillCount;
    logic                   byteLost;
    logic                   nextByteLost;
    logic [TIMER_W-1:0]     flushTimer;
    logic [TIMER_W-1:0]     nextFlushTimer;
    rxCtrlPkg::ifaceState_e ifaceState;
    rxCtrlPkg::ifaceState_e nextIfaceState;
    logic bufEmpty;
    logic allowPop;
    logic doPop;
    logic canPush;
    logic doPush;
    logic flushBuf;

    assign bufEmpty = (fillCount == 2'd0);
    // Data packets hold back two bytes until a newer one shows the older is not CRC
    assign allowPop      = (gotByte_i && (fillCount == 2'd2)) || !needCrc16_i;
    assign rxDataValid_o = allowPop && !bufEmpty;
    assign rxData_o      = bufMem[rdPtr];
    assign doPop         = rxDataValid_o && rxAccept_i;
    assign canPush       = (fillCount != 2'd2) || doPop;
    assign doPush        = gotByte_i && canPush;
    assign keepPacket_o  = !(dropPacket_i || byteLost);
    // CRC16 bytes are thrown away at EOP, a bad packet at once
    assign flushBuf      = (gotEop_i && needCrc16_i) || !keepPacket_o;

    // ==============================
    // Two entry byte buffer
    // ==============================
    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            rdPtr     <= 1'b0;
            wrPtr     <= 1'b0;
            fillCount <= 2'd0;
        end else if (flushBuf) begin
            rdPtr     <= 1'b0;
            wrPtr     <= 1'b0;
            fillCount <= 2'd0;
        end else begin
            if (doPush) begin
                wrPtr <= !wrPtr;
            end
            if (doPop) begin
                rdPtr <= !rdPtr;
            end
            fillCount <= fillCount + 2'(doPush) - 2'(doPop);
        end
    end

    always_ff @(posedge clk12_i) begin
        if (doPush) begin
            bufMem[wrPtr] <= byteData_i;
        end
    end

    always_comb begin
        rxDone_o       = 1'b0;
        nextIfaceState = ifaceState;
        nextFlushTimer = flushTimer;
        // Byte arriving into a full buffer is lost
        nextByteLost   = byteLost || (gotByte_i && !canPush);
        unique case (ifaceState)
            rxCtrlPkg::KEEP_FILLED: begin
                nextFlushTimer = TIMER_W'(FLUSH_TIMEOUT);
                if (gotEop_i) begin
                    nextIfaceState = rxCtrlPkg::WAIT_EMPTY;
                end
            end
            rxCtrlPkg::WAIT_EMPTY: begin
                if (bufEmpty) begin
                    rxDone_o       = 1'b1;
                    nextByteLost   = 1'b0;
                    nextIfaceState = rxCtrlPkg::KEEP_FILLED;
                end else if (flushTimer == '0) begin
                    // Backend too slow, give up on the packet
                    nextByteLost = 1'b1;
                end else begin
                    nextFlushTimer = flushTimer - 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            ifaceState <= rxCtrlPkg::KEEP_FILLED;
            byteLost   <= 1'b0;
            flushTimer <= TIMER_W'(FLUSH_TIMEOUT);
        end else begin
            ifaceState <= nextIfaceState;
            byteLost   <= nextByteLost;
            flushTimer <= nextFlushTimer;
        end
    end

endmodule

`default_nettype wire

/* hdl/rxPacketFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module rxPacketFsm (
    input  wire logic       clk12_i,
    input  wire logic       rstN_i,
    input  wire logic [7:0] byteData_i,
    input  wire logic       byteFull_i,
    input  wire logic       syncDetect_i,
    input  wire logic       crcOk_i,
    input  wire logic       stuffError_i,
    input  wire logic       lineValid_i,
    input  wire logic       eopDetected_i,
    output logic            decoderRestart_o,
    output logic            shiftRestart_o,
    output logic            shiftClear_o,
    output logic            crcRestart_o,
    output logic            useCrc16_o,
    output logic            ackEop_o,
    output logic            gotByte_o,
    output logic            gotEop_o,
    output logic            dropPacket_o,
    output logic            needCrc16_o
);

    rxCtrlPkg::rxState_e     rxState;
    rxCtrlPkg::rxState_e     nextRxState;
    usbPacketPkg::pidByte_u  pidByte;
    logic needCrc16;
    logic nextNeedCrc16;
    logic dropPacket;
    logic nextDropPacket;
    logic lastCrcOk;
    logic nextLastCrcOk;
    logic byteSigError;
    logic lineBad;
    logic signalError;
    logic byteDropCheck;
    logic pidValid;
    logic inPacket;
    logic inEop;

    // PID check nibble must be the complement of the value
    assign pidByte  = byteData_i;
    assign pidValid = (pidByte.nibbles.pidCheck == ~pidByte.nibbles.pidValue);

    assign signalError   = lineBad || stuffError_i;
    // Stuffing rule still holds for the bit after a byte
    assign byteDropCheck = byteFull_i && (byteSigError || stuffError_i);

    assign inPacket = (rxState == rxCtrlPkg::GET_PID) || (rxState == rxCtrlPkg::WAIT_EOP);
    assign inEop    = (rxState == rxCtrlPkg::WAIT_EOP);

    // ==============================
    // Control strobes
    // ==============================
    assign gotByte_o        = inPacket && byteFull_i;
    // A byte finishing in the same cycle is handled first
    assign ackEop_o         = inEop && eopDetected_i && !byteFull_i;
    assign gotEop_o         = ackEop_o;
    assign shiftRestart_o   = (rxState == rxCtrlPkg::WAIT_SYNC) && syncDetect_i;
    // CRC starts with the first bit after the PID
    assign crcRestart_o     = (rxState == rxCtrlPkg::GET_PID) && !byteFull_i;
    assign decoderRestart_o = (rxState == rxCtrlPkg::RST_PHASE);
    assign shiftClear_o     = (rxState == rxCtrlPkg::RST_PHASE);
    assign useCrc16_o       = needCrc16;
    assign needCrc16_o      = needCrc16;
    assign dropPacket_o     = dropPacket;

    always_comb begin
        nextRxState    = rxState;
        nextNeedCrc16  = needCrc16;
        nextDropPacket = dropPacket;
        nextLastCrcOk  = lastCrcOk;
        unique case (rxState)
            rxCtrlPkg::WAIT_SYNC: begin
                if (syncDetect_i) begin
                    nextRxState    = rxCtrlPkg::GET_PID;
                    nextDropPacket = 1'b0;
                end
            end
            rxCtrlPkg::GET_PID: begin
                nextDropPacket = dropPacket || byteDropCheck || (byteFull_i && !pidValid);
                if (byteFull_i) begin
                    nextRxState   = rxCtrlPkg::WAIT_EOP;
                    // Only data packets carry CRC16
                    nextNeedCrc16 = (pidByte.fields.pidType == usbPacketPkg::PID_TYPE_DATA);
                end
            end
            rxCtrlPkg::WAIT_EOP: begin
                nextDropPacket = dropPacket || byteDropCheck || (ackEop_o && !lastCrcOk);
                if (byteFull_i) begin
                    // CRC state as of the last complete byte
                    nextLastCrcOk = crcOk_i;
                end else if (eopDetected_i) begin
                    nextRxState = rxCtrlPkg::RST_PHASE;
                end
            end
            rxCtrlPkg::RST_PHASE: begin
                nextRxState   = rxCtrlPkg::WAIT_SYNC;
                // PID-only packets have no CRC to check
                nextLastCrcOk = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            rxState      <= rxCtrlPkg::WAIT_SYNC;
            needCrc16    <= 1'b0;
            dropPacket   <= 1'b0;
            lastCrcOk    <= 1'b1;
            byteSigError <= 1'b0;
            lineBad      <= 1'b0;
        end else begin
            rxState    <= nextRxState;
            needCrc16  <= nextNeedCrc16;
            dropPacket <= nextDropPacket;
            lastCrcOk  <= nextLastCrcOk;
            // Delayed to line up with the NRZI decoder output
            lineBad    <= !lineValid_i;
            // The bit on the decoder output here already belongs to the new byte
            if (shiftRestart_o || byteFull_i) begin
                byteSigError <= signalError;
            end else begin
                byteSigError <= byteSigError || signalError;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/usbCrcCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module usbCrcCheck (
    input  wire logic clk12_i,
    input  wire logic rstN_i,
    input  wire logic restart_i,
    input  wire logic useCrc16_i,
    input  wire logic bit_i,
    input  wire logic bitValid_i,
    output logic      crcOk_o
);

    logic [4:0]  crc5;
    logic [15:0] crc16;
    logic        fb5;
    logic        fb16;

    // Feedback taps from the top bit
    assign fb5  = crc5[4] ^ bit_i;
    assign fb16 = crc16[15] ^ bit_i;

    // ==============================
    // Both registers run on every valid bit
    // ==============================
    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            crc5  <= '1;
            crc16 <= '1;
        end else if (restart_i) begin
            // Preset value for a new packet
            crc5  <= '1;
            crc16 <= '1;
        end else if (bitValid_i) begin
            crc5  <= {crc5[3:0], 1'b0} ^ (fb5 ? usbPacketPkg::CRC5_POLY : 5'd0);
            crc16 <= {crc16[14:0], 1'b0} ^ (fb16 ? usbPacketPkg::CRC16_POLY : 16'd0);
        end
    end

    // Data and CRC bits together leave a fixed residual
    always_comb begin
        if (useCrc16_i) begin
            crcOk_o = (crc16 == usbPacketPkg::CRC16_RESIDUAL);
        end else begin
            crcOk_o = (crc5 == usbPacketPkg::CRC5_RESIDUAL);
        end
    end

endmodule

`default_nettype wire

/* hdl/usbPacketPkg.sv */
`default_nettype none

package usbPacketPkg;

    // Newest four decoded SYNC bits, newest bit in the MSB
    localparam logic [3:0] SYNC_TAIL = 4'b1000;

    // PID type field values
    localparam logic [1:0] PID_TYPE_DATA  = 2'b11;
    localparam logic [1:0] PID_TYPE_TOKEN = 2'b01;

    // Generator polynomials without the leading term
    localparam logic [4:0]  CRC5_POLY  = 5'b00101;
    localparam logic [15:0] CRC16_POLY = 16'h8005;

    // Register contents left over after a packet with correct CRC
    localparam logic [4:0]  CRC5_RESIDUAL  = 5'b01100;
    localparam logic [15:0] CRC16_RESIDUAL = 16'h800D;

    // A stuffed zero follows this many ones
    localparam int STUFF_RUN = 6;

    // ==============================
    // PID byte as received, in natural bit order
    // ==============================
    typedef union packed {
        struct packed {
            logic [3:0] pidCheck;
            logic [3:0] pidValue;
        } nibbles;
        struct packed {
            logic [3:0] pidCheck;
            logic [1:0] pidName;
            logic [1:0] pidType;
        } fields;
    } pidByte_u;

endpackage

`default_nettype wire

/* hdl/usbRx.sv */
`timescale 1ns/1ps
`default_nettype none

module usbRx #(
    parameter int FLUSH_TIMEOUT = rxCtrlPkg::FLUSH_TIMEOUT_DEFAULT
) (
    input  wire logic       clk12_i,
    input  wire logic       rstN_i,
    input  wire logic       dataP_i,
    input  wire logic       lineValid_i,
    input  wire logic       eopDetected_i,
    input  wire logic       rxAccept_i,
    output logic            ackEop_o,
    output logic            rxDataValid_o,
    output logic      [7:0] rxData_o,
    output logic            rxDone_o,
    output logic            keepPacket_o
);

    // Bit level
    logic       decodedBit;
    logic       bitValid;
    logic       stuffError;
    // Byte level
    logic [7:0] byteData;
    logic       byteFull;
    logic       syncDetect;
    logic       crcOk;
    // Packet control
    logic       decoderRestart;
    logic       shiftRestart;
    logic       shiftClear;
    logic       crcRestart;
    logic       useCrc16;
    logic       gotByte;
    logic       gotEop;
    logic       dropPacket;
    logic       needCrc16;

    nrziUnstuff lineDecoder (
        .clk12_i      (clk12_i),
        .rstN_i       (rstN_i),
        .restart_i    (decoderRestart),
        .dataP_i      (dataP_i),
        .decodedBit_o (decodedBit),
        .bitValid_o   (bitValid),
        .stuffError_o (stuffError)
    );

    rxDeserializer byteShifter (
        .clk12_i      (clk12_i),
        .rstN_i       (rstN_i),
        .restart_i    (shiftRestart),
        .clear_i      (shiftClear),
        .bit_i        (decodedBit),
        .bitValid_i   (bitValid),
        .byteData_o   (byteData),
        .byteFull_o   (byteFull),
        .syncDetect_o (syncDetect)
    );

    usbCrcCheck crcChecker (
        .clk12_i    (clk12_i),
        .rstN_i     (rstN_i),
        .restart_i  (crcRestart),
        .useCrc16_i (useCrc16),
        .bit_i      (decodedBit),
        .bitValid_i (bitValid),
        .crcOk_o    (crcOk)
    );

    rxPacketFsm packetFsm (
        .clk12_i          (clk12_i),
        .rstN_i           (rstN_i),
        .byteData_i       (byteData),
        .byteFull_i       (byteFull),
        .syncDetect_i     (syncDetect),
        .crcOk_i          (crcOk),
        .stuffError_i     (stuffError),
        .lineValid_i      (lineValid_i),
        .eopDetected_i    (eopDetected_i),
        .decoderRestart_o (decoderRestart),
        .shiftRestart_o   (shiftRestart),
        .shiftClear_o     (shiftClear),
        .crcRestart_o     (crcRestart),
        .useCrc16_o       (useCrc16),
        .ackEop_o         (ackEop_o),
        .gotByte_o        (gotByte),
        .gotEop_o         (gotEop),
        .dropPacket_o     (dropPacket),
        .needCrc16_o      (needCrc16)
    );

    rxOutputStage #(
        .FLUSH_TIMEOUT (FLUSH_TIMEOUT)
    ) outputStage (
        .clk12_i       (clk12_i),
        .rstN_i        (rstN_i),
        .gotByte_i     (gotByte),
        .byteData_i    (byteData),
        .gotEop_i      (gotEop),
        .dropPacket_i  (dropPacket),
        .needCrc16_i   (needCrc16),
        .rxAccept_i    (rxAccept_i),
        .rxDataValid_o (rxDataValid_o),
        .rxData_o      (rxData_o),
        .rxDone_o      (rxDone_o),
        .keepPacket_o  (keepPacket_o)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usbRxTb -f all.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -qx "sim passed" \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }

/* verif/usbRxAssertions.sv */
`timescale 1ns/1ps
`default_nettype none

module usbRxAssertions (
    input wire logic       clk12_i,
    input wire logic       rstN_i,
    input wire logic       valid_i,
    input wire logic [7:0] data_i,
    input wire logic       accept_i,
    input wire logic       done_i
);

    // Done ends a packet, no byte may be offered in that cycle
    doneNotWithValid: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        !(done_i && valid_i))
        else $error("done and valid high in the same cycle");

    // Offered byte holds until taken or withdrawn
    dataStable: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        (valid_i && !accept_i) |=> (!valid_i || $stable(data_i)))
        else $error("byte changed while valid and not accepted");

    // Done is a single cycle pulse
    doneOneCycle: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        done_i |=> !done_i)
        else $error("done held longer than one cycle");

endmodule

bind rxOutputStage usbRxAssertions outputChecks (
    .clk12_i  (clk12_i),
    .rstN_i   (rstN_i),
    .valid_i  (rxDataValid_o),
    .data_i   (rxData_o),
    .accept_i (rxAccept_i),
    .done_i   (rxDone_o)
);

`default_nettype wire

/* verif/usbRxTb.sv */
`timescale 1ns/1ps
`default_nettype none

module usbRxTb;

    localparam int CLK_PERIOD     = 4;
    localparam int NUM_PKTS       = 11;
    localparam int MAX_PKT_CYCLES = 120;
    // Corruption kinds
    localparam logic [1:0] CORR_NONE = 2'd0;
    localparam logic [1:0] CORR_CRC  = 2'd1;
    localparam logic [1:0] CORR_LINE = 2'd2;
    localparam logic [1:0] CORR_PID  = 2'd3;

    typedef struct packed {
        logic [7:0]  pid;
        logic [2:0]  nBytes;
        logic [31:0] payload;
        logic [1:0]  corrupt;
        logic        pressure;
        logic        keep;
    } pktEntry_t;

    logic       clk12;
    logic       rstN;
    logic       dataP;
    logic       lineValid;
    logic       eopDetected;
    logic       rxAccept;
    logic       ackEop;
    logic       rxDataValid;
    logic [7:0] rxData;
    logic       rxDone;
    logic       keepPacket;

    pktEntry_t  pktTable [NUM_PKTS];
    bit         pktBits[$];
    bit         lineBits[$];
    logic [7:0] expBytes[$];
    logic [7:0] rxBytes[$];
    int         errorCount;
    int         failedPkts;
    int         gapLeft;
    logic       doneSeen;
    logic       doneKeep;
    logic       pressureOn;

    usbRx u_dut (
        .clk12_i       (clk12),
        .rstN_i        (rstN),
        .dataP_i       (dataP),
        .lineValid_i   (lineValid),
        .eopDetected_i (eopDetected),
        .rxAccept_i    (rxAccept),
        .ackEop_o      (ackEop),
        .rxDataValid_o (rxDataValid),
        .rxData_o      (rxData),
        .rxDone_o      (rxDone),
        .keepPacket_o  (keepPacket)
    );

    initial clk12 = 1'b0;
    always #(CLK_PERIOD / 2) clk12 = ~clk12;

    // Outputs are stable at the falling edge
    always @(negedge clk12) begin
        if (rxDataValid && rxAccept) begin
            rxBytes.push_back(rxData);
        end
        if (rxDone) begin
            doneSeen = 1'b1;
            doneKeep = keepPacket;
        end
    end

    // Random accept gaps of 1 to 7 cycles, always with a high cycle between
    always @(posedge clk12) begin
        if (!pressureOn) begin
            rxAccept <= 1'b1;
            gapLeft  <= 0;
        end else if (gapLeft != 0) begin
            rxAccept <= 1'b0;
            gapLeft  <= gapLeft - 1;
        end else if (rxAccept && $urandom_range(0, 2) == 0) begin
            rxAccept <= 1'b0;
            gapLeft  <= $urandom_range(0, 6);
        end else begin
            rxAccept <= 1'b1;
        end
    end

    // Watchdog sized from the packet table
    initial begin
        #(NUM_PKTS * MAX_PKT_CYCLES * 4 * CLK_PERIOD);
        $display("Timeout: the DUT did not finish all packets in time");
        $display("sim failed");
        $finish;
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, actual,
                     expected);
            errorCount++;
        end
    endtask

    // ==============================
    // Packet table
    // ==============================
    task automatic loadTable();
        pktTable[0]  = '{8'hD2, 3'd0, 32'h0000_0000, CORR_NONE, 1'b0, 1'b1};
        pktTable[1]  = '{8'hE1, 3'd2, 32'h0000_0315, CORR_NONE, 1'b0, 1'b1};
        pktTable[2]  = '{8'hC3, 3'd4, 32'hFFFF_0201, CORR_NONE, 1'b0, 1'b1};
        pktTable[3]  = '{8'h4B, 3'd2, 32'h0000_3CA5, CORR_CRC,  1'b0, 1'b0};
        pktTable[4]  = '{8'hC3, 3'd3, 32'h0011_2233, CORR_LINE, 1'b0, 1'b0};
        pktTable[5]  = '{8'h69, 3'd2, 32'h0000_0782, CORR_CRC,  1'b0, 1'b0};
        pktTable[6]  = '{8'hC3, 3'd2, 32'h0000_AA55, CORR_PID,  1'b0, 1'b0};
        pktTable[7]  = '{8'h69, 3'd2, 32'h0000_05FE, CORR_NONE, 1'b1, 1'b1};
        pktTable[8]  = '{8'hD2, 3'd0, 32'h0000_0000, CORR_NONE, 1'b1, 1'b1};
        pktTable[9]  = '{8'h2D, 3'd2, 32'h0000_0100, CORR_NONE, 1'b1, 1'b1};
        pktTable[10] = '{8'h4B, 3'd3, 32'h0080_7F3E, CORR_NONE, 1'b0, 1'b1};
    endtask

    // USB CRC over the bits after the PID, register preset to all ones
    function automatic logic [15:0] crcOver(input int first, input bit use16);
        logic [15:0] crc;
        logic        fb;
        crc = '1;
        for (int i = first; i < pktBits.size(); i++) begin
            if (use16) begin
                fb  = crc[15] ^ pktBits[i];
                crc = {crc[14:0], 1'b0} ^ (fb ? usbPacketPkg::CRC16_POLY : 16'h0);
            end else begin
                fb       = crc[4] ^ pktBits[i];
                crc[4:0] = {crc[3:0], 1'b0} ^ (fb ? usbPacketPkg::CRC5_POLY : 5'h0);
            end
        end
        return crc;
    endfunction

    // Packet bits LSB first, CRC inverted and MSB first, plus the bytes to expect
    task automatic buildPacket(input pktEntry_t pkt);
        usbPacketPkg::pidByte_u pid;
        logic [15:0]            crc;
        logic [7:0]             byteVal;
        int                     nData;
        pktBits.delete();
        expBytes.delete();
        pid = pkt.pid;
        if (pkt.corrupt == CORR_PID) begin
            pid.nibbles.pidCheck = pid.nibbles.pidCheck ^ 4'b0100;
        end
        for (int i = 0; i < 8; i++) begin
            pktBits.push_back(pid[i]);
        end
        if (pid.fields.pidType == usbPacketPkg::PID_TYPE_TOKEN) begin
            // Address and endpoint fill 11 bits
            for (int i = 0; i < 11; i++) begin
                pktBits.push_back(pkt.payload[i]);
            end
            crc = crcOver(8, 1'b0);
            for (int i = 4; i >= 0; i--) begin
                pktBits.push_back(!crc[i]);
            end
        end else if (pid.fields.pidType == usbPacketPkg::PID_TYPE_DATA) begin
            for (int i = 0; i < 8 * int'(pkt.nBytes); i++) begin
                pktBits.push_back(pkt.payload[i]);
            end
            crc = crcOver(8, 1'b1);
            for (int i = 15; i >= 0; i--) begin
                pktBits.push_back(!crc[i]);
            end
        end
        nData = pktBits.size() / 8;
        // Data packets keep their CRC16 to themselves
        if (pid.fields.pidType == usbPacketPkg::PID_TYPE_DATA) begin
            nData = nData - 2;
        end
        for (int b = 0; b < nData; b++) begin
            for (int j = 0; j < 8; j++) begin
                byteVal[j] = pktBits[8 * b + j];
            end
            expBytes.push_back(byteVal);
        end
        if (pkt.corrupt == CORR_CRC) begin
            pktBits[pktBits.size() - 1] = !pktBits[pktBits.size() - 1];
        end
    endtask

    // SYNC then packet, with a zero after every six ones
    task automatic stuffBits();
        int ones;
        bit b;
        lineBits.delete();
        ones = 0;
        for (int i = 0; i < 8 + pktBits.size(); i++) begin
            b = (i < 8) ? (i == 7) : pktBits[i - 8];
            lineBits.push_back(b);
            ones = b ? ones + 1 : 0;
            if (ones == usbPacketPkg::STUFF_RUN) begin
                lineBits.push_back(1'b0);
                ones = 0;
            end
        end
    endtask

    // NRZI: a zero toggles the line, idle is J
    task automatic drivePacket(input pktEntry_t pkt);
        logic level;
        int   badIdx;
        level  = 1'b1;
        badIdx = (pkt.corrupt == CORR_LINE) ? 20 : -1;
        for (int i = 0; i < lineBits.size(); i++) begin
            @(posedge clk12);
            if (i == 0) begin
                pressureOn <= pkt.pressure;
            end
            if (!lineBits[i]) begin
                level = !level;
            end
            dataP     <= level;
            lineValid <= (i != badIdx);
        end
        @(posedge clk12);
        pressureOn <= 1'b0;
        repeat (3) @(posedge clk12);
        eopDetected <= 1'b1;
        @(negedge clk12);
        while (!ackEop) begin
            @(negedge clk12);
        end
        @(posedge clk12);
        eopDetected <= 1'b0;
        dataP       <= 1'b1;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int unsigned seedInit;
        int          errsBefore;
        seedInit    = $urandom(57913);
        rstN        = 1'b0;
        dataP       = 1'b1;
        lineValid   = 1'b1;
        eopDetected = 1'b0;
        rxAccept    = 1'b1;
        pressureOn  = 1'b0;
        gapLeft     = 0;
        doneSeen    = 1'b0;
        doneKeep    = 1'b1;
        errorCount  = 0;
        failedPkts  = 0;
        loadTable();
        repeat (10) @(posedge clk12);
        rstN <= 1'b1;
        repeat (8) @(posedge clk12);
        // Idle receiver: no ack, no byte, no done, keep high
        @(negedge clk12);
        checkValue(32'({ackEop, rxDataValid, rxDone, keepPacket}), 32'h1,
                   "outputs after reset");
        for (int k = 0; k < NUM_PKTS; k++) begin
            errsBefore = errorCount;
            buildPacket(pktTable[k]);
            stuffBits();
            rxBytes.delete();
            doneSeen = 1'b0;
            drivePacket(pktTable[k]);
            @(negedge clk12);
            while (!doneSeen) begin
                @(negedge clk12);
            end
            checkValue(32'(doneKeep), 32'(pktTable[k].keep), "keep flag");
            // Bytes of a dropped packet are not defined
            if (pktTable[k].keep) begin
                checkValue(32'(rxBytes.size()), 32'(expBytes.size()), "byte count");
                for (int i = 0; i < rxBytes.size() && i < expBytes.size(); i++) begin
                    checkValue(32'(rxBytes[i]), 32'(expBytes[i]), $sformatf("byte %0d", i));
                end
            end
            if (errorCount == errsBefore) begin
                $display("packet %0d pid %h: ok", k, pktTable[k].pid);
            end else begin
                failedPkts++;
                $display("packet %0d pid %h: FAILED", k, pktTable[k].pid);
            end
            repeat (6) @(posedge clk12);
        end
        $display("%0d packets, %0d failed, %0d mismatches", NUM_PKTS, failedPkts, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
